//--- tb.f
source/ctrl_pkg.sv
source/instr_decoder.sv
source/main_fsm.sv
source/control_signals.sv
source/control_unit.sv
test/control_unit_assert.sv
test/control_unit_tb.sv

//--- test/control_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit_tb;
        import ctrl_pkg::*;

        localparam int clk_period   = 40;
        localparam int reset_cycles = 16;
        localparam int n_rows       = 16;

        // Exit kinds
        localparam int k_rwrite    = 0;
        localparam int k_taken     = 1;
        localparam int k_not_taken = 2;
        localparam int k_load      = 3;
        localparam int k_store     = 4;
        localparam int k_jump      = 5;
        localparam int k_exc_ovf   = 6;
        localparam int k_exc_ill   = 7;

        logic clk = 1'b0;
        logic reset;
        logic [op_w-1:0] op;
        logic [funct_w-1:0] funct;
        logic overflow;
        logic equal;
        logic ack;
        pc_src_t pc_src;
        alu_src_a_t alu_src_a;
        alu_src_b_t alu_src_b;
        alu_op_t alu_op;
        iord_t iord;
        reg_dst_t reg_dst;
        reg_data_t reg_data;
        logic ir_write;
        logic pc_write;
        logic bank_write;
        logic epc_write;
        logic a_write;
        logic b_write;
        logic alu_out_write;
        logic mem_reg_write;
        logic cyc;
        logic stb;
        logic we;

        // Instruction table
        logic [op_w-1:0] row_op [n_rows];
        logic [funct_w-1:0] row_funct [n_rows];
        logic row_ovf [n_rows];
        logic row_eq [n_rows];
        int row_kind [n_rows];
        alu_op_t row_alu [n_rows];

        integer seed = 32'hdec7;
        logic bus_busy;
        int bus_wait;
        int bus_count;
        int wait_sum;
        int errors;
        int checks;
        int cur_row;

        control_unit dut (
                .clk           (clk),
                .reset         (reset),
                .op            (op),
                .funct         (funct),
                .overflow      (overflow),
                .equal         (equal),
                .ack           (ack),
                .pc_src        (pc_src),
                .alu_src_a     (alu_src_a),
                .alu_src_b     (alu_src_b),
                .alu_op        (alu_op),
                .iord          (iord),
                .reg_dst       (reg_dst),
                .reg_data      (reg_data),
                .ir_write      (ir_write),
                .pc_write      (pc_write),
                .bank_write    (bank_write),
                .epc_write     (epc_write),
                .a_write       (a_write),
                .b_write       (b_write),
                .alu_out_write (alu_out_write),
                .mem_reg_write (mem_reg_write),
                .cyc           (cyc),
                .stb           (stb),
                .we            (we)
        );

        always #(clk_period / 2) clk = ~clk;

        task automatic check_value(input string name, input int got, input int expected);
                checks++;
                assert (got == expected)
                else begin
                        errors++;
                        $display("ERR %0t row %0d %s: expected %0d got %0d",
                                 $time, cur_row, name, expected, got);
                end
        endtask

        task automatic set_row(input int i, input logic [op_w-1:0] o,
                               input logic [funct_w-1:0] f, input logic v, input logic e,
                               input int k, input alu_op_t a);
                row_op[i]    = o;
                row_funct[i] = f;
                row_ovf[i]   = v;
                row_eq[i]    = e;
                row_kind[i]  = k;
                row_alu[i]   = a;
        endtask

        task automatic fill_table();
                set_row(0, op_rtype, funct_add, 1'b0, 1'b0, k_rwrite, alu_add);
                set_row(1, op_rtype, funct_sub, 1'b0, 1'b1, k_rwrite, alu_sub);
                set_row(2, op_rtype, funct_and, 1'b0, 1'b0, k_rwrite, alu_and);
                set_row(3, op_rtype, funct_and, 1'b1, 1'b0, k_rwrite, alu_and);
                set_row(4, op_rtype, funct_add, 1'b1, 1'b0, k_exc_ovf, alu_add);
                set_row(5, op_rtype, funct_sub, 1'b1, 1'b0, k_exc_ovf, alu_sub);
                set_row(6, op_beq, 6'd0, 1'b0, 1'b1, k_taken, alu_sub);
                set_row(7, op_beq, 6'd0, 1'b0, 1'b0, k_not_taken, alu_sub);
                set_row(8, op_bne, 6'd0, 1'b0, 1'b0, k_taken, alu_sub);
                set_row(9, op_bne, 6'd0, 1'b0, 1'b1, k_not_taken, alu_sub);
                set_row(10, op_lw, 6'd0, 1'b0, 1'b0, k_load, alu_add);
                set_row(11, op_sw, 6'd0, 1'b0, 1'b0, k_store, alu_add);
                set_row(12, op_j, 6'd0, 1'b0, 1'b0, k_jump, alu_pass);
                set_row(13, 6'd63, 6'd0, 1'b0, 1'b0, k_exc_ill, alu_pass);
                set_row(14, op_rtype, 6'd0, 1'b0, 1'b0, k_exc_ill, alu_pass); // Shift is not kept
                set_row(15, op_rtype, funct_add, 1'b0, 1'b0, k_rwrite, alu_add);
        endtask

        // Cycles from first fetch cycle to next fetch with zero waits
        function automatic int base_cycles(input int kind);
                case (kind)
                        k_rwrite, k_taken, k_store, k_exc_ill: return 5;
                        k_load, k_exc_ovf: return 6;
                        default: return 4;
                endcase
        endfunction

        function automatic pc_src_t expected_pc_src(input int kind);
                case (kind)
                        k_taken: return pc_alu_out;
                        k_jump:  return pc_jump_target;
                        default: return pc_mem_load;
                endcase
        endfunction

        function automatic logic in_fetch();
                return cyc && stb && iord == iord_pc;
        endfunction

        // Wishbone slave stepped on each falling edge
        task automatic serve_bus();
                if (ack) begin
                        ack      = 1'b0;                // Transfer ended at the last edge
                        bus_busy = 1'b0;
                end
                if (cyc && stb && !bus_busy) begin
                        bus_wait  = $random(seed) & 3;
                        wait_sum += bus_wait;
                        bus_count = 0;
                        bus_busy  = 1'b1;
                end
                if (bus_busy) begin
                        if (bus_count == bus_wait) begin
                                ack = 1'b1;
                        end else begin
                                bus_count++;
                        end
                end
        endtask

        task automatic check_init();
                check_value("bank_write", bank_write, 1);
                check_value("reg_dst", reg_dst, dst_sp);
                check_value("reg_data", reg_data, data_sp_init);
                check_value("cyc", cyc, 0);
                check_value("stb", stb, 0);
                check_value("we", we, 0);
                check_value("ir_write", ir_write, 0);
                check_value("pc_write", pc_write, 0);
                check_value("epc_write", epc_write, 0);
                check_value("a_write", a_write, 0);
                check_value("b_write", b_write, 0);
                check_value("alu_out_write", alu_out_write, 0);
                check_value("mem_reg_write", mem_reg_write, 0);
        endtask

        task automatic run_row(input int r);
                int kind;
                int cycles;
                int ir_count;
                int pc_count;
                int bank_count;
                int epc_count;
                int a_count;
                int b_count;
                int ld_count;
                int st_count;
                logic fetch_acked;
                logic prev_fetch;
                logic done;
                logic alu_seen;
                logic aow_got;
                alu_op_t alu_got;
                alu_src_b_t src_b_got;
                pc_src_t pc_got;
                reg_dst_t dst_got;
                reg_data_t data_got;
                iord_t vec_exp;
                logic is_exc;

                kind     = row_kind[r];
                cur_row  = r;
                op       = row_op[r];
                funct    = row_funct[r];
                overflow = row_ovf[r];
                equal    = row_eq[r];
                cycles      = 0;
                ir_count    = 0;
                pc_count    = 0;
                bank_count  = 0;
                epc_count   = 0;
                a_count     = 0;
                b_count     = 0;
                ld_count    = 0;
                st_count    = 0;
                wait_sum    = 0;
                fetch_acked = 1'b0;
                done        = 1'b0;
                alu_seen    = 1'b0;
                aow_got     = 1'b0;
                alu_got     = alu_pass;
                src_b_got   = b_four;
                pc_got      = pc_alu_out;
                dst_got     = dst_rt;
                data_got    = data_alu_out;
                is_exc      = (kind == k_exc_ovf) || (kind == k_exc_ill);
                vec_exp     = (kind == k_exc_ovf) ? iord_vec_overflow : iord_vec_illegal;

                while (!done) begin
                        if (in_fetch()) begin
                                check_value("we", we, 0);
                        end
                        if (ir_write) begin
                                ir_count++;
                                check_value("pc_write", pc_write, 1);
                                check_value("fetch ack before ir_write", fetch_acked, 1);
                        end else if (pc_write) begin
                                pc_count++;
                                pc_got = pc_src;
                        end
                        if (bank_write) begin
                                bank_count++;
                                dst_got  = reg_dst;
                                data_got = reg_data;
                        end
                        if (epc_write) begin
                                epc_count++;
                                check_value("mem_reg_write", mem_reg_write, 1);
                                check_value("iord", iord, vec_exp);
                        end
                        if (a_write) begin
                                a_count++;
                                check_value("alu_src_b", alu_src_b, b_branch_offset);
                                check_value("alu_out_write", alu_out_write, 1);
                        end
                        if (b_write) begin
                                b_count++;
                        end
                        if (alu_src_a == a_reg_a && !alu_seen) begin     // Execute or compare
                                alu_seen  = 1'b1;
                                alu_got   = alu_op;
                                src_b_got = alu_src_b;
                                aow_got   = alu_out_write;
                        end
                        serve_bus();
                        fetch_acked = in_fetch() && ack;
                        if (cyc && stb && ack && iord == iord_alu_out) begin
                                if (we) begin
                                        st_count++;
                                end else begin
                                        ld_count++;
                                end
                        end
                        prev_fetch = in_fetch();
                        cycles++;
                        @(negedge clk);
                        done = in_fetch() && !prev_fetch;
                end

                check_value("cycles", cycles, base_cycles(kind) + wait_sum);
                check_value("ir_write pulses", ir_count, 1);
                check_value("a_write pulses", a_count, 1);
                check_value("b_write pulses", b_count, 1);
                check_value("alu_op", alu_got, row_alu[r]);
                if (kind != k_jump && kind != k_exc_ill) begin
                        check_value("alu_src_b", src_b_got,
                                    (kind == k_load || kind == k_store) ? b_immediate : b_reg_b);
                end
                if (kind == k_rwrite) begin
                        check_value("alu_out_write", aow_got, 1);
                        check_value("reg_dst", dst_got, dst_rd);
                        check_value("reg_data", data_got, data_alu_out);
                end
                if (kind == k_load) begin
                        check_value("reg_dst", dst_got, dst_rt);
                        check_value("reg_data", data_got, data_mem_data);
                end
                check_value("bank_write pulses", bank_count,
                            (kind == k_rwrite || kind == k_load) ? 1 : 0);
                check_value("pc_write pulses", pc_count,
                            (kind == k_taken || kind == k_jump || is_exc) ? 1 : 0);
                if (pc_count == 1) begin
                        check_value("pc_src", pc_got, expected_pc_src(kind));
                end
                check_value("epc_write seen", epc_count != 0, is_exc);
                check_value("data reads", ld_count, kind == k_load);
                check_value("data writes", st_count, kind == k_store);
        endtask

        initial begin
                reset    = 1'b1;
                op       = '0;
                funct    = '0;
                overflow = 1'b0;
                equal    = 1'b0;
                ack      = 1'b0;
                bus_busy = 1'b0;
                errors   = 0;
                checks   = 0;
                cur_row  = -1;
                fill_table();
                repeat (reset_cycles) begin
                        @(negedge clk);
                        check_init();
                end
                reset = 1'b0;
                @(negedge clk);
                check_value("cyc after reset", cyc, 1);
                check_value("iord after reset", iord, iord_pc);
                for (int r = 0; r < n_rows; r++) begin
                        run_row(r);
                end
                $display("Checks: %0d, check errors: %0d, assertion errors: %0d",
                         checks, errors, dut.u_chk.fail_count);
                if (errors + dut.u_chk.fail_count == 0) begin
                        $display("Done: no errors");
                end else begin
                        $display("Done: errors found");
                end
                $finish;
        end

        // Longest instruction is well under 20 cycles
        initial begin
                #((reset_cycles + n_rows * 20) * clk_period);
                $display("Watchdog: the instruction sequence did not finish in time");
                $display("Done: errors found");
                $finish;
        end

endmodule

`default_nettype wire

//--- test/control_unit_assert.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit_assert (
        input logic clk,
        input logic reset,
        input logic cyc,
        input logic stb,
        input logic we,
        input logic ack
);
        int fail_count = 0;

        a_stb_in_cycle: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
                else begin
                        fail_count++;
                        $error("stb high while cyc is low");
                end

        // Master keeps the request up until the slave answers
        a_hold_until_ack: assert property (@(posedge clk) disable iff (reset)
                (cyc && stb && !ack) |=> (cyc && stb))
                else begin
                        fail_count++;
                        $error("cyc or stb dropped before ack");
                end

        a_we_in_transfer: assert property (@(posedge clk) disable iff (reset)
                we |-> (cyc && stb))
                else begin
                        fail_count++;
                        $error("we high outside a bus transfer");
                end

endmodule

bind control_unit control_unit_assert u_chk (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .ack   (ack)
);

`default_nettype wire

//--- source/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit (
        input  logic                          clk,
        input  logic                          reset,
        input  logic [ctrl_pkg::op_w-1:0]     op,
        input  logic [ctrl_pkg::funct_w-1:0]  funct,
        input  logic                          overflow,
        input  logic                          equal,
        input  logic                          ack,
        output ctrl_pkg::pc_src_t             pc_src,
        output ctrl_pkg::alu_src_a_t          alu_src_a,
        output ctrl_pkg::alu_src_b_t          alu_src_b,
        output ctrl_pkg::alu_op_t             alu_op,
        output ctrl_pkg::iord_t               iord,
        output ctrl_pkg::reg_dst_t            reg_dst,
        output ctrl_pkg::reg_data_t           reg_data,
        output logic                          ir_write,
        output logic                          pc_write,
        output logic                          bank_write,
        output logic                          epc_write,
        output logic                          a_write,
        output logic                          b_write,
        output logic                          alu_out_write,
        output logic                          mem_reg_write,
        output logic                          cyc,
        output logic                          stb,
        output logic                          we
);
        import ctrl_pkg::*;

        state_t decoded_state;
        state_t state;
        cause_t cause;

        instr_decoder u_decoder (
                .op            (op),
                .funct         (funct),
                .decoded_state (decoded_state)
        );

        main_fsm u_fsm (
                .clk           (clk),
                .reset         (reset),
                .decoded_state (decoded_state),
                .overflow      (overflow),
                .equal         (equal),
                .ack           (ack),
                .state         (state),
                .cause         (cause)
        );

        // Moore outputs, no input reaches them directly
        control_signals u_signals (
                .state         (state),
                .cause         (cause),
                .pc_src        (pc_src),
                .alu_src_a     (alu_src_a),
                .alu_src_b     (alu_src_b),
                .alu_op        (alu_op),
                .iord          (iord),
                .reg_dst       (reg_dst),
                .reg_data      (reg_data),
                .ir_write      (ir_write),
                .pc_write      (pc_write),
                .bank_write    (bank_write),
                .epc_write     (epc_write),
                .a_write       (a_write),
                .b_write       (b_write),
                .alu_out_write (alu_out_write),
                .mem_reg_write (mem_reg_write),
                .cyc           (cyc),
                .stb           (stb),
                .we            (we)
        );

endmodule

`default_nettype wire

//--- source/control_signals.sv
`timescale 1ns/10ps
`default_nettype none

module control_signals (
        input  ctrl_pkg::state_t   state,
        input  ctrl_pkg::cause_t   cause,
        output ctrl_pkg::pc_src_t    pc_src,
        output ctrl_pkg::alu_src_a_t alu_src_a,
        output ctrl_pkg::alu_src_b_t alu_src_b,
        output ctrl_pkg::alu_op_t    alu_op,
        output ctrl_pkg::iord_t      iord,
        output ctrl_pkg::reg_dst_t   reg_dst,
        output ctrl_pkg::reg_data_t  reg_data,
        output logic               ir_write,
        output logic               pc_write,
        output logic               bank_write,
        output logic               epc_write,
        output logic               a_write,
        output logic               b_write,
        output logic               alu_out_write,
        output logic               mem_reg_write,
        output logic               cyc,
        output logic               stb,
        output logic               we
);
        import ctrl_pkg::*;

        always_comb begin
                pc_src        = pc_alu_out;
                alu_src_a     = a_pc;
                alu_src_b     = b_reg_b;
                alu_op        = alu_pass;
                iord          = iord_pc;
                reg_dst       = dst_rt;
                reg_data      = data_alu_out;
                ir_write      = 1'b0;
                pc_write      = 1'b0;
                bank_write    = 1'b0;
                epc_write     = 1'b0;
                a_write       = 1'b0;
                b_write       = 1'b0;
                alu_out_write = 1'b0;
                mem_reg_write = 1'b0;
                cyc           = 1'b0;
                stb           = 1'b0;
                we            = 1'b0;

                case (state)
                        init_sp: begin
                                bank_write = 1'b1;
                                reg_dst    = dst_sp;
                                reg_data   = data_sp_init;
                        end
                        fetch: begin
                                cyc           = 1'b1;
                                stb           = 1'b1;
                                alu_src_b     = b_four;         // PC + 4
                                alu_op        = alu_add;
                                alu_out_write = 1'b1;
                        end
                        ir_load: begin
                                ir_write = 1'b1;
                                pc_write = 1'b1;
                        end
                        decode: begin
                                // Branch target computed early
                                alu_src_b     = b_branch_offset;
                                alu_op        = alu_add;
                                alu_out_write = 1'b1;
                                a_write       = 1'b1;
                                b_write       = 1'b1;
                        end
                        exec_add, exec_sub, exec_and: begin
                                alu_src_a     = a_reg_a;
                                alu_src_b     = b_reg_b;
                                alu_op        = (state == exec_add) ? alu_add :
                                                (state == exec_sub) ? alu_sub : alu_and;
                                alu_out_write = 1'b1;
                        end
                        r_write: begin
                                bank_write = 1'b1;
                                reg_dst    = dst_rd;
                        end
                        branch_eq, branch_ne: begin
                                alu_src_a = a_reg_a;            // Compare only, alu_out keeps target
                                alu_op    = alu_sub;
                        end
                        branch_take: begin
                                pc_write = 1'b1;
                        end
                        lw_addr, sw_addr: begin
                                alu_src_a     = a_reg_a;
                                alu_src_b     = b_immediate;
                                alu_op        = alu_add;
                                alu_out_write = 1'b1;
                        end
                        lw_access: begin
                                cyc           = 1'b1;
                                stb           = 1'b1;
                                iord          = iord_alu_out;
                                mem_reg_write = 1'b1;
                        end
                        sw_access: begin
                                cyc  = 1'b1;
                                stb  = 1'b1;
                                we   = 1'b1;
                                iord = iord_alu_out;
                        end
                        lw_write: begin
                                bank_write = 1'b1;
                                reg_data   = data_mem_data;
                        end
                        jump: begin
                                pc_write = 1'b1;
                                pc_src   = pc_jump_target;
                        end
                        exc_vector: begin
                                cyc           = 1'b1;
                                stb           = 1'b1;
                                alu_src_b     = b_four;         // EPC gets PC - 4
                                alu_op        = alu_sub;
                                epc_write     = 1'b1;
                                mem_reg_write = 1'b1;
                                iord          = (cause == cause_overflow) ? iord_vec_overflow :
                                                                            iord_vec_illegal;
                        end
                        exc_jump: begin
                                pc_write = 1'b1;
                                pc_src   = pc_mem_load;
                        end
                        default: begin
                        end
                endcase
        end

endmodule

`default_nettype wire

//--- source/main_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module main_fsm (
        input  logic             clk,
        input  logic             reset,
        input  ctrl_pkg::state_t decoded_state,
        input  logic             overflow,
        input  logic             equal,
        input  logic             ack,
        output ctrl_pkg::state_t state,
        output ctrl_pkg::cause_t cause
);
        import ctrl_pkg::*;

        state_t next_state;
        cause_t next_cause;

        always_comb begin
                next_state = state;                     // Bus states hold by default
                next_cause = cause;
                case (state)
                        init_sp: begin
                                next_state = fetch;
                        end
                        fetch: begin
                                if (ack) begin
                                        next_state = ir_load;
                                end
                        end
                        ir_load: begin
                                next_state = decode;
                        end
                        decode: begin
                                next_state = decoded_state;
                                if (decoded_state == exc_vector) begin
                                        next_cause = cause_illegal;
                                end
                        end

                        // Overflow is sampled while the ALU still works on A and B
                        exec_add, exec_sub: begin
                                if (overflow) begin
                                        next_state = exc_vector;
                                        next_cause = cause_overflow;
                                end else begin
                                        next_state = r_write;
                                end
                        end
                        exec_and: begin
                                next_state = r_write;
                        end
                        r_write: begin
                                next_state = fetch;
                        end
                        branch_eq: begin
                                next_state = equal ? branch_take : fetch;
                        end
                        branch_ne: begin
                                next_state = equal ? fetch : branch_take;
                        end
                        branch_take: begin
                                next_state = fetch;
                        end
                        lw_addr: begin
                                next_state = lw_access;
                        end
                        lw_access: begin
                                if (ack) begin
                                        next_state = lw_write;
                                end
                        end
                        lw_write: begin
                                next_state = fetch;
                        end
                        sw_addr: begin
                                next_state = sw_access;
                        end
                        sw_access: begin
                                if (ack) begin
                                        next_state = fetch;
                                end
                        end
                        jump: begin
                                next_state = fetch;
                        end
                        exc_vector: begin
                                if (ack) begin
                                        next_state = exc_jump;
                                end
                        end
                        exc_jump: begin
                                next_state = fetch;
                        end
                        default: begin
                                next_state = fetch;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= init_sp;               // SP init write runs here
                        cause <= cause_illegal;
                end else begin
                        state <= next_state;
                        cause <= next_cause;
                end
        end

endmodule

`default_nettype wire

//--- source/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
        input  logic [ctrl_pkg::op_w-1:0]    op,
        input  logic [ctrl_pkg::funct_w-1:0] funct,
        output ctrl_pkg::state_t             decoded_state
);
        import ctrl_pkg::*;

        always_comb begin
                decoded_state = exc_vector;             // Unknown codes trap
                case (op)
                        op_rtype: begin
                                case (funct)
                                        funct_add: decoded_state = exec_add;
                                        funct_sub: decoded_state = exec_sub;
                                        funct_and: decoded_state = exec_and;
                                        default:   decoded_state = exc_vector;
                                endcase
                        end
                        op_beq: begin
                                decoded_state = branch_eq;
                        end
                        op_bne: begin
                                decoded_state = branch_ne;
                        end
                        op_lw: begin
                                decoded_state = lw_addr;
                        end
                        op_sw: begin
                                decoded_state = sw_addr;
                        end
                        op_j: begin
                                decoded_state = jump;
                        end
                        default: begin
                                decoded_state = exc_vector;
                        end
                endcase
        end

endmodule

`default_nettype wire

//--- source/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

        localparam int op_w    = 6;
        localparam int funct_w = 6;

        // Opcodes
        localparam logic [op_w-1:0] op_rtype = 6'd0;
        localparam logic [op_w-1:0] op_j     = 6'd2;
        localparam logic [op_w-1:0] op_beq   = 6'd4;
        localparam logic [op_w-1:0] op_bne   = 6'd5;
        localparam logic [op_w-1:0] op_lw    = 6'd35;
        localparam logic [op_w-1:0] op_sw    = 6'd43;

        // R-type function codes
        localparam logic [funct_w-1:0] funct_add = 6'd32;
        localparam logic [funct_w-1:0] funct_sub = 6'd34;
        localparam logic [funct_w-1:0] funct_and = 6'd36;

        // Sequencer states
        typedef enum logic [4:0] {
                init_sp,
                fetch,
                ir_load,
                decode,
                exec_add,
                exec_sub,
                exec_and,
                r_write,
                branch_eq,
                branch_ne,
                branch_take,
                lw_addr,
                lw_access,
                lw_write,
                sw_addr,
                sw_access,
                jump,
                exc_vector,
                exc_jump
        } state_t;

        typedef enum logic {cause_illegal, cause_overflow} cause_t;

        typedef enum logic [1:0] {
                pc_alu_out, pc_alu_result, pc_jump_target, pc_mem_load
        } pc_src_t;

        typedef enum logic [1:0] {a_pc, a_reg_a, a_reg_b} alu_src_a_t;

        typedef enum logic [1:0] {
                b_reg_b, b_four, b_immediate, b_branch_offset
        } alu_src_b_t;

        typedef enum logic [1:0] {alu_pass, alu_add, alu_sub, alu_and} alu_op_t;

        // Memory address source, vectors are fixed in the datapath
        typedef enum logic [1:0] {
                iord_pc, iord_alu_out, iord_vec_illegal, iord_vec_overflow
        } iord_t;

        typedef enum logic [1:0] {dst_rt, dst_rd, dst_sp} reg_dst_t;

        typedef enum logic [1:0] {data_alu_out, data_mem_data, data_sp_init} reg_data_t;

endpackage

`default_nettype wire
